/* blitter.f */
hw/blit_bus_pkg.sv
hw/blit_regs_pkg.sv
hw/blit_reg_queue.sv
hw/blit_sequencer.sv
hw/blit_data_path.sv
hw/blitter.sv
tests/vram_model.sv
tests/blitter_tb.sv

/* hw/blit_bus_pkg.sv */
// VRAM bus types for the blitter: data word, word address, nibble mask and request
package blit_bus_pkg;

    localparam int WORD_W  = 16;                    // VRAM data width
    localparam int ADDR_W  = 16;                    // 64K-word address space
    localparam int NIB_W   = 4;
    localparam int NIBBLES = WORD_W / NIB_W;        // nibbles per word

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [NIBBLES-1:0] nib_mask_t;         // bit n enables nibble n

    // full request as seen by VRAM, held until ack
    typedef struct packed {
        logic      sel;                             // access requested
        logic      wr;                              // 1 write, 0 read
        addr_t     addr;
        nib_mask_t wr_mask;                         // only meaningful on writes
        word_t     data;                            // write data
    } vram_req_t;

endpackage

/* hw/blit_data_path.sv */
// Blit data path: source capture, nibble shifter, logic op and transparency mask
`timescale 1ns/1ns

module blit_data_path (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        setup_i,
    input  logic                        capture_i,     // source read acked
    input  blit_regs_pkg::blit_params_t params_i,
    input  blit_bus_pkg::nib_mask_t     pos_mask_i,
    input  blit_bus_pkg::word_t         rd_data_i,
    output blit_bus_pkg::word_t         wr_data_o,
    output blit_bus_pkg::nib_mask_t     wr_mask_o
);

    localparam int NIB_W   = blit_bus_pkg::NIB_W;
    localparam int CARRY_W = blit_bus_pkg::WORD_W - NIB_W;     // three nibbles kept

    blit_bus_pkg::word_t     val_s;                 // source value for the next write
    logic [CARRY_W-1:0]      last_s;                // low nibbles of the previous read
    blit_bus_pkg::word_t     shifted;
    blit_bus_pkg::nib_mask_t transp_mask;

    // right shift, vacated top nibbles come from the previous read
    always_comb begin
        case (params_i.shift.amount)
            2'd0:    shifted = rd_data_i;
            2'd1:    shifted = {last_s[3:0], rd_data_i[15:4]};
            2'd2:    shifted = {last_s[7:0], rd_data_i[15:8]};
            default: shifted = {last_s[11:0], rd_data_i[15:12]};
        endcase
    end

    // clear a nibble's enable when it matches the transparent key
    always_comb begin
        for (int i = 0; i < blit_bus_pkg::NIBBLES; i++) begin
            transp_mask[i] = !params_i.ctrl.transp_en ||
                             (val_s[i*NIB_W +: NIB_W] != (i[0] ? params_i.ctrl.transp_t[7:4]
                                                              : params_i.ctrl.transp_t[3:0]));
        end
    end

    assign wr_data_o = (val_s & ~params_i.andc) ^ params_i.xorc;
    assign wr_mask_o = pos_mask_i & transp_mask;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            val_s  <= '0;
            last_s <= '0;
        end else if (setup_i) begin
            val_s  <= params_i.src_s;               // constant source, if used
            last_s <= '0;                           // no carry into a new blit
        end else if (capture_i) begin
            val_s  <= shifted;
            last_s <= rd_data_i[CARRY_W-1:0];
        end
    end

endmodule

/* hw/blit_reg_queue.sv */
// Blitter register queue: decodes host register writes and holds one pending blit
`timescale 1ns/1ns

module blit_reg_queue (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              reg_wr_i,
    input  logic [blit_regs_pkg::REG_NUM_W-1:0] reg_num_i,
    input  blit_regs_pkg::reg_word_u          reg_data_i,
    input  logic                              setup_i,     // sequencer took the blit
    output logic                              queued_o,
    output blit_regs_pkg::blit_params_t       params_o
);

    logic words_wr;                                         // this write queues a blit

    assign words_wr = reg_wr_i && (reg_num_i == blit_regs_pkg::REG_WORDS);

    // field registers, written in place
    always_ff @(posedge clk) begin
        if (reg_wr_i) begin
            case (reg_num_i)
                blit_regs_pkg::REG_CTRL: begin
                    params_o.ctrl <= reg_data_i.ctrl;
                end
                blit_regs_pkg::REG_ANDC: begin
                    params_o.andc <= reg_data_i.raw;
                end
                blit_regs_pkg::REG_XOR: begin
                    params_o.xorc <= reg_data_i.raw;
                end
                blit_regs_pkg::REG_MOD_S: begin
                    params_o.mod_s <= reg_data_i.raw;
                end
                blit_regs_pkg::REG_SRC_S: begin
                    params_o.src_s <= reg_data_i.raw;
                end
                blit_regs_pkg::REG_MOD_D: begin
                    params_o.mod_d <= reg_data_i.raw;
                end
                blit_regs_pkg::REG_DST_D: begin
                    params_o.dst_d <= reg_data_i.raw;
                end
                blit_regs_pkg::REG_SHIFT: begin
                    params_o.shift <= reg_data_i.shift;
                end
                blit_regs_pkg::REG_LINES: begin
                    params_o.lines <= reg_data_i.raw;
                end
                blit_regs_pkg::REG_WORDS: begin
                    params_o.words <= reg_data_i.raw;
                end
                default: begin
                end
            endcase
        end
    end

    // new blit wins over the setup clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            queued_o <= 1'b0;
        end else if (words_wr) begin
            queued_o <= 1'b1;
        end else if (setup_i) begin
            queued_o <= 1'b0;
        end
    end

endmodule

/* hw/blit_regs_pkg.sv */
// Blitter register map, register word layouts and the per-blit parameter set
package blit_regs_pkg;

    localparam int REG_NUM_W = 4;

    localparam logic [REG_NUM_W-1:0] REG_CTRL  = 4'd0;
    localparam logic [REG_NUM_W-1:0] REG_ANDC  = 4'd1;
    localparam logic [REG_NUM_W-1:0] REG_XOR   = 4'd2;
    localparam logic [REG_NUM_W-1:0] REG_MOD_S = 4'd3;
    localparam logic [REG_NUM_W-1:0] REG_SRC_S = 4'd4;
    localparam logic [REG_NUM_W-1:0] REG_MOD_D = 4'd5;
    localparam logic [REG_NUM_W-1:0] REG_DST_D = 4'd6;
    localparam logic [REG_NUM_W-1:0] REG_SHIFT = 4'd7;
    localparam logic [REG_NUM_W-1:0] REG_LINES = 4'd8;
    localparam logic [REG_NUM_W-1:0] REG_WORDS = 4'd9;     // write queues the blit

    // CTRL word, msb first
    typedef struct packed {
        logic [7:0] transp_t;               // hi nibble for odd, lo nibble for even nibbles
        logic [2:0] unused_hi;
        logic       transp_en;
        logic [2:0] unused_lo;
        logic       s_const;                // source comes from SRC_S, no reads
    } ctrl_reg_t;

    // SHIFT word, msb first
    typedef struct packed {
        logic [3:0] f_mask;                 // first word of each line
        logic [3:0] l_mask;                 // last word of each line
        logic [5:0] unused;
        logic [1:0] amount;                 // right shift in nibbles
    } shift_reg_t;

    // one host data word, seen raw or as one of the field layouts
    typedef union packed {
        blit_bus_pkg::word_t raw;
        ctrl_reg_t           ctrl;
        shift_reg_t          shift;
    } reg_word_u;

    typedef struct packed {
        ctrl_reg_t           ctrl;
        shift_reg_t          shift;
        blit_bus_pkg::word_t andc;          // source bits to clear
        blit_bus_pkg::word_t xorc;          // bits to flip after the and
        blit_bus_pkg::word_t mod_s;         // added to source addr after each line
        blit_bus_pkg::word_t src_s;         // source addr, or constant source
        blit_bus_pkg::word_t mod_d;
        blit_bus_pkg::word_t dst_d;
        blit_bus_pkg::word_t lines;         // line count minus one
        blit_bus_pkg::word_t words;         // words per line minus one
    } blit_params_t;

endpackage

/* hw/blit_sequencer.sv */
// Blit sequencer: FSM, line and word counters, address stepping and VRAM request
`timescale 1ns/1ns

module blit_sequencer (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        queued_i,
    input  blit_regs_pkg::blit_params_t queued_params_i,
    input  logic                        vram_ack_i,
    output logic                        setup_o,
    output logic                        capture_o,
    output blit_regs_pkg::blit_params_t params_o,
    output blit_bus_pkg::nib_mask_t     pos_mask_o,
    output logic                        sel_o,
    output logic                        wr_o,
    output blit_bus_pkg::addr_t         addr_o,
    output logic                        busy_o,
    output logic                        done_o
);

    localparam int LINE_W  = 16;                    // msb is the last line flag
    localparam int COUNT_W = 17;                    // msb is the last word flag

    typedef enum logic [2:0] {
        IDLE,
        SETUP,                                      // take queued params
        LINE_BEG,                                   // load word count, start first access
        RD_S,
        WR_D,
        LINE_END                                    // modulo step, next line or finish
    } blit_state_t;

    blit_state_t                 state, state_next;
    blit_regs_pkg::blit_params_t active;
    blit_bus_pkg::addr_t         src_addr, src_next;
    blit_bus_pkg::addr_t         dst_addr, dst_next;
    blit_bus_pkg::addr_t         addr_next;
    logic [LINE_W-1:0]           lines, lines_next;
    logic [COUNT_W-1:0]          count, count_next;
    blit_bus_pkg::nib_mask_t     f_mask, f_mask_next;
    logic                        sel_next, wr_next, done_next;
    logic                        advance;           // no pending access
    logic                        last_word, last_line;

    assign advance   = !sel_o || vram_ack_i;
    assign last_word = count[COUNT_W-1];
    assign last_line = lines[LINE_W-1];

    assign setup_o    = (state == SETUP);
    assign capture_o  = (state == RD_S) && vram_ack_i;
    assign busy_o     = (state != IDLE);
    assign params_o   = setup_o ? queued_params_i : active;   // new blit visible on setup
    assign pos_mask_o = f_mask & (last_word ? active.shift.l_mask : '1);

    always_comb begin
        state_next  = state;
        sel_next    = 1'b0;
        wr_next     = 1'b0;
        addr_next   = addr_o;
        src_next    = src_addr;
        dst_next    = dst_addr;
        lines_next  = lines;
        count_next  = count;
        f_mask_next = f_mask;
        done_next   = 1'b0;

        case (state)
            IDLE: begin
                if (queued_i) begin
                    state_next = SETUP;
                end
            end
            SETUP: begin
                src_next   = queued_params_i.src_s;
                dst_next   = queued_params_i.dst_d;
                lines_next = queued_params_i.lines;
                state_next = LINE_BEG;
            end
            LINE_BEG: begin
                f_mask_next = active.shift.f_mask;
                lines_next  = lines - 1'b1;                     // underflow marks last line
                count_next  = {1'b0, active.words} - 1'b1;      // underflow marks last word
                sel_next    = 1'b1;
                if (!active.ctrl.s_const) begin
                    addr_next  = src_addr;
                    state_next = RD_S;
                end else begin
                    wr_next    = 1'b1;
                    addr_next  = dst_addr;
                    state_next = WR_D;
                end
            end
            RD_S: begin
                src_next   = addr_o + 1'b1;
                sel_next   = 1'b1;
                wr_next    = 1'b1;
                addr_next  = dst_addr;
                state_next = WR_D;
            end
            WR_D: begin
                dst_next    = addr_o + 1'b1;
                addr_next   = addr_o + 1'b1;                    // next dest for const fill
                count_next  = count - 1'b1;
                f_mask_next = '1;                               // first word is behind us
                if (last_word) begin
                    state_next = LINE_END;
                end else if (!active.ctrl.s_const) begin
                    sel_next   = 1'b1;
                    addr_next  = src_addr;
                    state_next = RD_S;
                end else begin
                    sel_next   = 1'b1;
                    wr_next    = 1'b1;
                    state_next = WR_D;
                end
            end
            LINE_END: begin
                src_next = src_addr + active.mod_s;
                dst_next = dst_addr + active.mod_d;
                if (last_line) begin
                    done_next  = 1'b1;
                    state_next = queued_i ? SETUP : IDLE;
                end else begin
                    state_next = LINE_BEG;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // control state, held while an access waits for ack
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state  <= IDLE;
            sel_o  <= 1'b0;
            wr_o   <= 1'b0;
            done_o <= 1'b0;
        end else if (advance) begin
            state  <= state_next;
            sel_o  <= sel_next;
            wr_o   <= wr_next;
            done_o <= done_next;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (setup_o) begin
                active <= queued_params_i;
            end
            addr_o   <= addr_next;
            src_addr <= src_next;
            dst_addr <= dst_next;
            lines    <= lines_next;
            count    <= count_next;
            f_mask   <= f_mask_next;
        end
    end

endmodule

/* hw/blitter.sv */
// Nibble blitter top: register queue, sequencer and data path on one VRAM port
`timescale 1ns/1ns

module blitter (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                reg_wr_i,
    input  logic [blit_regs_pkg::REG_NUM_W-1:0] reg_num_i,
    input  blit_regs_pkg::reg_word_u            reg_data_i,
    output logic                                busy_o,
    output logic                                full_o,
    output logic                                done_o,
    output blit_bus_pkg::vram_req_t             vram_o,
    input  logic                                vram_ack_i,
    input  blit_bus_pkg::word_t                 vram_data_i
);

    blit_regs_pkg::blit_params_t queued_params;
    blit_regs_pkg::blit_params_t active_params;
    logic                        queued;
    logic                        setup;
    logic                        capture;
    logic                        sel;
    logic                        wr;
    blit_bus_pkg::addr_t         addr;
    blit_bus_pkg::nib_mask_t     pos_mask;
    blit_bus_pkg::nib_mask_t     wr_mask;
    blit_bus_pkg::word_t         wr_data;

    assign full_o = queued;                         // one blit waiting
    assign vram_o = '{sel: sel, wr: wr, addr: addr, wr_mask: wr_mask, data: wr_data};

    blit_reg_queue u_queue (
        .clk        (clk),
        .reset_i    (reset_i),
        .reg_wr_i   (reg_wr_i),
        .reg_num_i  (reg_num_i),
        .reg_data_i (reg_data_i),
        .setup_i    (setup),
        .queued_o   (queued),
        .params_o   (queued_params)
    );

    blit_sequencer u_seq (
        .clk             (clk),
        .reset_i         (reset_i),
        .queued_i        (queued),
        .queued_params_i (queued_params),
        .vram_ack_i      (vram_ack_i),
        .setup_o         (setup),
        .capture_o       (capture),
        .params_o        (active_params),
        .pos_mask_o      (pos_mask),
        .sel_o           (sel),
        .wr_o            (wr),
        .addr_o          (addr),
        .busy_o          (busy_o),
        .done_o          (done_o)
    );

    blit_data_path u_data (
        .clk        (clk),
        .reset_i    (reset_i),
        .setup_i    (setup),
        .capture_i  (capture),
        .params_i   (active_params),
        .pos_mask_i (pos_mask),
        .rd_data_i  (vram_data_i),
        .wr_data_o  (wr_data),
        .wr_mask_o  (wr_mask)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the blitter testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module blitter_tb -f blitter.f \
    --Mdir obj_dir -o blitter_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/blitter_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F '*** TEST PASSED ***' sim.log; then
    exit 0
fi
exit 1

/* tests/blitter_tb.sv */
// Blitter testbench: random blits on a VRAM model, checked against a nibble reference model
`timescale 1ns/1ns

module blitter_tb;

    localparam int          WIN  = 4096;                // preloaded and checked VRAM window
    localparam int          WAIT = 5000;                // cycles before a wait gives up
    localparam logic [31:0] TAPS = 32'h8020_0003;

    logic                                clk = 1'b0;
    logic                                reset_i = 1'b1;
    logic                                reg_wr_i = 1'b0;
    logic [blit_regs_pkg::REG_NUM_W-1:0] reg_num_i = '0;
    blit_regs_pkg::reg_word_u            reg_data_i = '0;
    logic                                busy_o;
    logic                                full_o;
    logic                                done_o;
    logic                                vram_ack;
    blit_bus_pkg::vram_req_t             vram_req;
    blit_bus_pkg::vram_req_t             prev_req;
    blit_bus_pkg::word_t                 vram_data;
    logic                                load_en = 1'b0;
    blit_bus_pkg::addr_t                 load_addr = '0;
    blit_bus_pkg::word_t                 load_data = '0;
    logic [1:0]                          ack_delay = '0;
    logic [31:0]                         lfsr = 32'd81684;
    logic                                prev_pending = 1'b0;   // last cycle's access unacked
    blit_bus_pkg::word_t                 ref_mem [WIN];
    blit_bus_pkg::addr_t                 exp_rd [$];            // source reads still to come

    always #50 clk = ~clk;

    blitter uut (
        .clk (clk), .reset_i (reset_i),
        .reg_wr_i (reg_wr_i), .reg_num_i (reg_num_i), .reg_data_i (reg_data_i),
        .busy_o (busy_o), .full_o (full_o), .done_o (done_o),
        .vram_o (vram_req), .vram_ack_i (vram_ack), .vram_data_i (vram_data)
    );

    vram_model u_vram (
        .clk (clk), .reset_i (reset_i), .req_i (vram_req), .delay_i (ack_delay),
        .load_en_i (load_en), .load_addr_i (load_addr), .load_data_i (load_data),
        .ack_o (vram_ack), .rd_data_o (vram_data)
    );

    function automatic blit_bus_pkg::word_t rand_bits(input int n);
        blit_bus_pkg::word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[14:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? TAPS : 32'd0);
        end
        return r;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input blit_bus_pkg::word_t got, exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s is 0x%04h, expected 0x%04h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input blit_bus_pkg::addr_t got, exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s is 0x%04h, expected 0x%04h", name, got, exp));
        end
    endtask

    // one clock, then a fresh ack delay for the VRAM model
    task automatic next_cycle;
        blit_bus_pkg::word_t r;
        @(posedge clk);
        #5;
        r = rand_bits(2);
        ack_delay = r[1:0];
    endtask

    task automatic wait_flag(input bit on_done, input string name);
        int n;
        n = 0;
        while (on_done ? !done_o : !busy_o) begin
            if (n == WAIT) begin
                abort_run($sformatf("timeout waiting for %s", name));
            end
            next_cycle();
            n++;
        end
    endtask

    task automatic write_reg(input logic [3:0] num, input blit_bus_pkg::word_t data);
        reg_wr_i       = 1'b1;
        reg_num_i      = num;
        reg_data_i.raw = data;
        next_cycle();
        reg_wr_i       = 1'b0;
    endtask

    task automatic program_blit(input blit_regs_pkg::blit_params_t p);
        write_reg(blit_regs_pkg::REG_CTRL, p.ctrl);
        write_reg(blit_regs_pkg::REG_ANDC, p.andc);
        write_reg(blit_regs_pkg::REG_XOR, p.xorc);
        write_reg(blit_regs_pkg::REG_MOD_S, p.mod_s);
        write_reg(blit_regs_pkg::REG_SRC_S, p.src_s);
        write_reg(blit_regs_pkg::REG_MOD_D, p.mod_d);
        write_reg(blit_regs_pkg::REG_DST_D, p.dst_d);
        write_reg(blit_regs_pkg::REG_SHIFT, p.shift);
        write_reg(blit_regs_pkg::REG_LINES, p.lines);
        write_reg(blit_regs_pkg::REG_WORDS, p.words);       // queues the blit
    endtask

    // sources in 0x000-0x7ff, destinations in 0x800-0xfff, never overlapping
    function automatic blit_regs_pkg::blit_params_t random_params(input logic s_const,
                                                                  input logic transp,
                                                                  input logic multi);
        blit_regs_pkg::blit_params_t p;
        blit_bus_pkg::word_t         r;
        p = '0;
        p.ctrl.s_const   = s_const;
        p.ctrl.transp_en = transp;
        r = rand_bits(10);
        p.shift.f_mask   = r[3:0];
        p.shift.l_mask   = r[7:4];
        p.shift.amount   = r[9:8];
        p.andc           = rand_bits(16);
        p.xorc           = rand_bits(16);
        p.src_s          = s_const ? rand_bits(16) : rand_bits(10);
        p.dst_d          = 16'h0800 | rand_bits(10);
        r = rand_bits(8);
        p.ctrl.transp_t  = s_const ? p.src_s[7:0] : r[7:0];    // fills always hit the key
        p.mod_s          = rand_bits(4);
        p.mod_d          = rand_bits(4);
        r = rand_bits(3);
        p.lines          = multi ? (r | 16'd1) : 16'd0;
        p.words          = rand_bits(4);
        return p;
    endfunction

    // applies one blit to the mirror and lists its source reads in order
    task automatic model_blit(input blit_regs_pkg::blit_params_t p);
        blit_bus_pkg::addr_t sa;
        blit_bus_pkg::addr_t da;
        blit_bus_pkg::word_t s;
        blit_bus_pkg::word_t d;
        logic [11:0]         carry;
        logic [27:0]         both;
        logic [3:0]          m;
        sa    = p.src_s;
        da    = p.dst_d;
        carry = '0;                                     // carry runs across lines
        for (int l = 0; l <= int'(p.lines); l++) begin
            for (int k = 0; k <= int'(p.words); k++) begin
                if (p.ctrl.s_const) begin
                    s = p.src_s;
                end else begin
                    exp_rd.push_back(sa);
                    both  = {carry, ref_mem[sa[11:0]]} >> (4 * p.shift.amount);
                    s     = both[15:0];
                    carry = ref_mem[sa[11:0]][11:0];
                    sa    = sa + 16'd1;
                end
                d = (s & ~p.andc) ^ p.xorc;
                m = 4'hf;
                if (k == 0) begin
                    m = m & p.shift.f_mask;
                end
                if (k == int'(p.words)) begin
                    m = m & p.shift.l_mask;
                end
                for (int i = 0; i < 4; i++) begin
                    if (p.ctrl.transp_en && s[4*i +: 4] == ((i % 2 != 0) ?
                            p.ctrl.transp_t[7:4] : p.ctrl.transp_t[3:0])) begin
                        m[i] = 1'b0;
                    end
                    if (m[i]) begin
                        ref_mem[da[11:0]][4*i +: 4] = d[4*i +: 4];
                    end
                end
                da = da + 16'd1;
            end
            sa = sa + p.mod_s;
            da = da + p.mod_d;
        end
    endtask

    // fills the window while checking that the idle blitter stays quiet
    task automatic preload_vram;
        blit_bus_pkg::word_t w;
        for (int a = 0; a < WIN; a++) begin
            w          = rand_bits(16);
            ref_mem[a] = w;
            load_en    = 1'b1;
            load_addr  = a[15:0];
            load_data  = w;
            next_cycle();
            check_flag("busy_o", busy_o, 1'b0);
            check_flag("full_o", full_o, 1'b0);
            check_flag("done_o", done_o, 1'b0);
            check_flag("vram_o.sel", vram_req.sel, 1'b0);
            check_flag("vram_o.wr", vram_req.wr, 1'b0);
        end
        load_en = 1'b0;
    endtask

    task automatic compare_memory;
        if (exp_rd.size() != 0) begin
            abort_run("blit finished before all expected source reads");
        end
        for (int a = 0; a < WIN; a++) begin
            check_word($sformatf("vram.mem[0x%03h]", a), u_vram.mem[a], ref_mem[a]);
        end
    endtask

    // done pulse lasts one cycle and leaves the blitter idle
    task automatic finish_blit;
        wait_flag(1'b1, "done_o");
        check_flag("busy_o", busy_o, 1'b0);
        next_cycle();
        check_flag("done_o", done_o, 1'b0);
        compare_memory();
    endtask

    task automatic run_single(input blit_regs_pkg::blit_params_t p);
        model_blit(p);
        program_blit(p);
        check_flag("full_o", full_o, 1'b1);
        finish_blit();
    endtask

    task automatic run_queued;
        blit_regs_pkg::blit_params_t p1;
        blit_regs_pkg::blit_params_t p2;
        p1 = random_params(1'b0, 1'b1, 1'b1);
        p1.words = p1.words | 16'd8;                    // outlasts the second setup
        p2 = random_params(1'b0, 1'b0, 1'b1);
        model_blit(p1);
        model_blit(p2);
        program_blit(p1);
        wait_flag(1'b0, "busy_o");
        program_blit(p2);
        check_flag("full_o", full_o, 1'b1);
        wait_flag(1'b1, "done_o");
        check_flag("full_o", full_o, 1'b1);             // second blit in setup right now
        check_flag("busy_o", busy_o, 1'b1);
        next_cycle();
        check_flag("full_o", full_o, 1'b0);
        check_flag("done_o", done_o, 1'b0);
        finish_blit();
    endtask

    // bus monitor: held requests and the order of source reads
    always @(negedge clk) begin
        if (!reset_i) begin
            if (prev_pending) begin
                if (vram_req !== prev_req) begin
                    abort_run("VRAM request changed while waiting for ack");
                end
            end else if (vram_req.sel && !vram_req.wr) begin
                if (exp_rd.size() == 0) begin
                    abort_run("VRAM read issued where no source read was expected");
                end else begin
                    check_addr("vram_o.addr", vram_req.addr, exp_rd.pop_front());
                end
            end
            prev_req     = vram_req;
            prev_pending = vram_req.sel && !vram_ack;
        end
    end

    initial begin
        blit_bus_pkg::word_t r;
        repeat (8) @(posedge clk);
        #5;
        reset_i = 1'b0;
        preload_vram();
        for (int n = 0; n < 4; n++) begin
            run_single(random_params(1'b0, 1'b0, 1'b0));    // single line copies
        end
        for (int n = 0; n < 3; n++) begin
            run_single(random_params(1'b1, 1'b1, 1'b1));    // keyed constant fills
        end
        for (int n = 0; n < 4; n++) begin
            r = rand_bits(1);
            run_single(random_params(1'b0, r[0], 1'b1));
        end
        run_queued();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* tests/vram_model.sv */
// VRAM model: 64K words with nibble write masks and acks after a chosen delay
`timescale 1ns/1ns

module vram_model (
    input  logic                    clk,
    input  logic                    reset_i,
    input  blit_bus_pkg::vram_req_t req_i,
    input  logic [1:0]              delay_i,        // wait cycles for the next request
    input  logic                    load_en_i,      // direct preload from the testbench
    input  blit_bus_pkg::addr_t     load_addr_i,
    input  blit_bus_pkg::word_t     load_data_i,
    output logic                    ack_o,
    output blit_bus_pkg::word_t     rd_data_o
);

    blit_bus_pkg::word_t mem [65536];
    logic [1:0]          wait_cnt;                  // cycles this request has waited
    logic [1:0]          delay_q;

    assign ack_o     = req_i.sel && (wait_cnt == delay_q);
    assign rd_data_o = mem[req_i.addr];             // valid in the ack cycle

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wait_cnt <= '0;
            delay_q  <= '0;
        end else if (ack_o) begin
            wait_cnt <= '0;
            delay_q  <= delay_i;
        end else if (req_i.sel) begin
            wait_cnt <= wait_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en_i) begin
            mem[load_addr_i] <= load_data_i;
        end else if (ack_o && req_i.wr) begin
            for (int i = 0; i < blit_bus_pkg::NIBBLES; i++) begin
                if (req_i.wr_mask[i]) begin
                    mem[req_i.addr][i*4 +: 4] <= req_i.data[i*4 +: 4];
                end
            end
        end
    end

endmodule
